// File: fp_format_pkg.sv
// Single-precision number format definitions
// Field widths, the operand layout, operand analysis flags
// and the one-hot class mask used by the non-computational FPU
package fp_format_pkg;

  // ------------------------------------------------------------
  // Format widths
  // ------------------------------------------------------------
  localparam int unsigned EXP_BITS = 8;
  localparam int unsigned MAN_BITS = 23;
  localparam int unsigned WIDTH    = 1 + EXP_BITS + MAN_BITS;

  // ------------------------------------------------------------
  // Operand and result word
  // ------------------------------------------------------------
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_t;

  // Result word seen as a float or as an integer boolean
  typedef union packed {
    fp_t              fp;
    logic [WIDTH-1:0] word;
  } fp_word_u;

  // Operand class flags
  typedef struct packed {
    logic normal;
    logic subnormal;
    logic zero;
    logic inf;
    logic nan;
    logic signalling;
  } fp_info_t;

  // One-hot class codes, bit 0 upward
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } classmask_e;

  // Positive quiet NaN with only the quiet bit set
  localparam fp_t CANON_QNAN = '{
    sign:     1'b0,
    exponent: '1,
    mantissa: {1'b1, {(MAN_BITS-1){1'b0}}}
  };

endpackage

// File: fp_op_pkg.sv
// Operation encodings and transaction types
// Opcodes, sub-operation codes, IEEE status flags and the
// request, response and per-part response structs
package fp_op_pkg;

  // ------------------------------------------------------------
  // Operation codes
  // ------------------------------------------------------------
  typedef enum logic [1:0] {
    SGNJ     = 2'd0,
    MINMAX   = 2'd1,
    CMP      = 2'd2,
    CLASSIFY = 2'd3
  } op_e;

  // Sub-operation meaning depends on the operation
  typedef logic [1:0] sub_op_e;

  // Sign injection
  localparam sub_op_e SUB_SGNJ  = 2'd0;
  localparam sub_op_e SUB_SGNJN = 2'd1;
  localparam sub_op_e SUB_SGNJX = 2'd2;
  localparam sub_op_e SUB_PASS  = 2'd3;
  // Minimum / maximum
  localparam sub_op_e SUB_MIN   = 2'd0;
  localparam sub_op_e SUB_MAX   = 2'd1;
  // Comparison
  localparam sub_op_e SUB_LE    = 2'd0;
  localparam sub_op_e SUB_LT    = 2'd1;
  localparam sub_op_e SUB_EQ    = 2'd2;

  // ------------------------------------------------------------
  // Status and transactions
  // ------------------------------------------------------------
  typedef struct packed {
    logic NV;  // invalid operation
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  localparam int unsigned TAG_BITS = 4;

  typedef struct packed {
    fp_format_pkg::fp_t  a;
    fp_format_pkg::fp_t  b;
    op_e                 op;
    sub_op_e             sub_op;
    logic                op_mod;
    logic [TAG_BITS-1:0] tag;
  } fp_req_t;

  typedef struct packed {
    fp_format_pkg::fp_word_u   result;
    status_t                   status;
    logic                      ext_bit;
    fp_format_pkg::classmask_e class_mask;
    logic                      is_class;
    logic [TAG_BITS-1:0]       tag;
  } fp_rsp_t;

  // What each result part hands to the selector
  typedef struct packed {
    fp_format_pkg::fp_word_u result;
    status_t                 status;
    logic                    ext_bit;
  } part_rsp_t;

  // Ordering conditions shared by both parts
  typedef struct packed {
    logic any_nan;
    logic signalling_nan;
    logic equal;
    logic a_smaller;
  } order_t;

endpackage

// File: fp_operand_analyzer.sv
// Operand analyzer
// Decodes both operands into class flags and works out the
// NaN, equality and ordering conditions in one place
`timescale 1ns/1ps

module fp_operand_analyzer (
  input  fp_format_pkg::fp_t     a_i,
  input  fp_format_pkg::fp_t     b_i,
  output fp_format_pkg::fp_info_t info_a_o,
  output fp_format_pkg::fp_info_t info_b_o,
  output fp_op_pkg::order_t       order_o
);

  import fp_format_pkg::*;

  logic [WIDTH-1:0] a_word;
  logic [WIDTH-1:0] b_word;

  // Same decode for both operands
  function automatic fp_info_t classify_operand(fp_t value);
    fp_info_t info;
    logic     exp_ones;
    logic     exp_zero;
    logic     man_zero;
    exp_ones = &value.exponent;
    exp_zero = ~|value.exponent;
    man_zero = ~|value.mantissa;
    info.normal     = ~exp_zero & ~exp_ones;
    info.subnormal  = exp_zero & ~man_zero;
    info.zero       = exp_zero & man_zero;
    info.inf        = exp_ones & man_zero;
    info.nan        = exp_ones & ~man_zero;
    // Quiet bit clear marks a signalling NaN
    info.signalling = info.nan & ~value.mantissa[MAN_BITS-1];
    return info;
  endfunction

  assign info_a_o = classify_operand(a_i);
  assign info_b_o = classify_operand(b_i);

  // ------------------------------------------------------------
  // Shared ordering conditions
  // ------------------------------------------------------------
  assign a_word = a_i;
  assign b_word = b_i;

  assign order_o.any_nan        = info_a_o.nan | info_b_o.nan;
  assign order_o.signalling_nan = info_a_o.signalling | info_b_o.signalling;
  // Plus and minus zero compare equal
  assign order_o.equal          = (a_word == b_word) | (info_a_o.zero & info_b_o.zero);
  // Magnitude order on the raw words, flipped once a sign is set
  assign order_o.a_smaller      = (a_word < b_word) ^ (a_i.sign | b_i.sign);

endmodule

// File: fp_sign_minmax.sv
// Sign-and-order result part
// Produces the sign-injection result and the minimum/maximum
// result side by side, each with its flags and extension bit
`timescale 1ns/1ps

module fp_sign_minmax (
  input  fp_format_pkg::fp_t      a_i,
  input  fp_format_pkg::fp_t      b_i,
  input  fp_format_pkg::fp_info_t info_a_i,
  input  fp_format_pkg::fp_info_t info_b_i,
  input  fp_op_pkg::order_t       order_i,
  input  fp_op_pkg::sub_op_e      sub_op_i,
  input  logic                    op_mod_i,
  output fp_op_pkg::part_rsp_t    sgnj_o,
  output fp_op_pkg::part_rsp_t    minmax_o
);

  import fp_format_pkg::*;
  import fp_op_pkg::*;

  // ------------------------------------------------------------
  // Sign injection
  // ------------------------------------------------------------
  always_comb begin : sign_injection
    fp_t sgnj_val;
    // Magnitude always comes from operand A
    sgnj_val = a_i;
    unique case (sub_op_i)
      SUB_SGNJ:  sgnj_val.sign = b_i.sign;
      SUB_SGNJN: sgnj_val.sign = ~b_i.sign;
      SUB_SGNJX: sgnj_val.sign = a_i.sign ^ b_i.sign;
      SUB_PASS:  sgnj_val      = a_i;
      default:   sgnj_val      = a_i;
    endcase
    // No exceptions from sign injection
    sgnj_o           = '0;
    sgnj_o.result.fp = sgnj_val;
    // op_mod asks for integer sign extension of the result
    sgnj_o.ext_bit   = op_mod_i ? sgnj_val.sign : 1'b1;
  end

  // ------------------------------------------------------------
  // Minimum / maximum
  // ------------------------------------------------------------
  always_comb begin : min_max
    minmax_o           = '0;
    // Quiet comparison, only sNaN is invalid
    minmax_o.status.NV = order_i.signalling_nan;
    // Float result, NaN-boxed in a wider register
    minmax_o.ext_bit   = 1'b1;
    if (info_a_i.nan && info_b_i.nan) begin
      minmax_o.result.fp = CANON_QNAN;
    end else if (info_a_i.nan) begin
      // The number wins over a single NaN
      minmax_o.result.fp = b_i;
    end else if (info_b_i.nan) begin
      minmax_o.result.fp = a_i;
    end else begin
      unique case (sub_op_i)
        SUB_MIN: minmax_o.result.fp = order_i.a_smaller ? a_i : b_i;
        SUB_MAX: minmax_o.result.fp = order_i.a_smaller ? b_i : a_i;
        default: minmax_o.result.fp = CANON_QNAN;
      endcase
    end
  end

endmodule

// File: fp_compare_class.sv
// Compare-and-classify result part
// Produces the boolean comparison word with its invalid flag
// and the one-hot class mask of operand A
`timescale 1ns/1ps

module fp_compare_class (
  input  fp_format_pkg::fp_t         a_i,
  input  fp_format_pkg::fp_info_t    info_a_i,
  input  fp_op_pkg::order_t          order_i,
  input  fp_op_pkg::sub_op_e         sub_op_i,
  input  logic                       op_mod_i,
  output fp_op_pkg::part_rsp_t       cmp_o,
  output fp_format_pkg::classmask_e  class_mask_o
);

  import fp_format_pkg::*;
  import fp_op_pkg::*;

  // ------------------------------------------------------------
  // Comparisons
  // ------------------------------------------------------------
  always_comb begin : comparison
    logic cmp_bit;
    cmp_bit = 1'b0;
    cmp_o   = '0;
    if (order_i.signalling_nan) begin
      // sNaN compares false and is always invalid
      cmp_o.status.NV = 1'b1;
    end else begin
      unique case (sub_op_i)
        SUB_LE: begin
          // Signalling relation, any NaN is invalid
          if (order_i.any_nan) cmp_o.status.NV = 1'b1;
          else cmp_bit = (order_i.a_smaller | order_i.equal) ^ op_mod_i;
        end
        SUB_LT: begin
          if (order_i.any_nan) cmp_o.status.NV = 1'b1;
          else cmp_bit = (order_i.a_smaller & ~order_i.equal) ^ op_mod_i;
        end
        SUB_EQ: begin
          // Quiet relation, NaN is simply unequal
          if (order_i.any_nan) cmp_bit = op_mod_i;
          else cmp_bit = order_i.equal ^ op_mod_i;
        end
        default: cmp_bit = 1'b0;
      endcase
    end
    // Boolean lands in bit 0 of an integer word
    cmp_o.result.word = {{(WIDTH-1){1'b0}}, cmp_bit};
    cmp_o.ext_bit     = 1'b0;
  end

  // ------------------------------------------------------------
  // Classification of operand A
  // ------------------------------------------------------------
  always_comb begin : classify
    if (info_a_i.normal) begin
      class_mask_o = a_i.sign ? NEGNORM : POSNORM;
    end else if (info_a_i.subnormal) begin
      class_mask_o = a_i.sign ? NEGSUBNORM : POSSUBNORM;
    end else if (info_a_i.zero) begin
      class_mask_o = a_i.sign ? NEGZERO : POSZERO;
    end else if (info_a_i.inf) begin
      class_mask_o = a_i.sign ? NEGINF : POSINF;
    end else if (info_a_i.signalling) begin
      class_mask_o = SNAN;
    end else begin
      // Only quiet NaN is left
      class_mask_o = QNAN;
    end
  end

endmodule

// File: fp_result_select.sv
// Result selector
// Picks the part response by operation and builds the full
// response with class mask, class flag and tag attached
`timescale 1ns/1ps

module fp_result_select (
  input  fp_op_pkg::op_e                 op_i,
  input  logic [fp_op_pkg::TAG_BITS-1:0] tag_i,
  input  fp_op_pkg::part_rsp_t           sgnj_i,
  input  fp_op_pkg::part_rsp_t           minmax_i,
  input  fp_op_pkg::part_rsp_t           cmp_i,
  input  fp_format_pkg::classmask_e      class_mask_i,
  output fp_op_pkg::fp_rsp_t             rsp_o
);

  import fp_op_pkg::*;

  part_rsp_t part_sel;

  always_comb begin : select_part
    unique case (op_i)
      SGNJ:     part_sel = sgnj_i;
      MINMAX:   part_sel = minmax_i;
      CMP:      part_sel = cmp_i;
      // Class result travels on the mask, word and flags stay clear
      CLASSIFY: part_sel = '0;
      default:  part_sel = '0;
    endcase
  end

  // ------------------------------------------------------------
  // Response assembly
  // ------------------------------------------------------------
  assign rsp_o.result     = part_sel.result;
  assign rsp_o.status     = part_sel.status;
  assign rsp_o.ext_bit    = part_sel.ext_bit;
  // Mask rides along for every op and is only meaningful with is_class
  assign rsp_o.class_mask = class_mask_i;
  assign rsp_o.is_class   = (op_i == CLASSIFY);
  assign rsp_o.tag        = tag_i;

endmodule

// File: fp_pipe_stages.sv
// Output pipeline
// NumPipeRegs valid/ready register stages carrying the response
// Ready runs backward combinationally, a bubble can be overwritten
`timescale 1ns/1ps

module fp_pipe_stages #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               in_valid_i,
  input  fp_op_pkg::fp_rsp_t in_rsp_i,
  output logic               in_ready_o,
  output logic               out_valid_o,
  output fp_op_pkg::fp_rsp_t out_rsp_o,
  input  logic               out_ready_i
);

  import fp_op_pkg::*;

  // Index i holds the response after i register stages
  fp_rsp_t pipe_rsp_q   [0:NumPipeRegs];
  logic    pipe_valid_q [0:NumPipeRegs];
  logic    pipe_ready   [0:NumPipeRegs];

  // Stage 0 is the combinational input
  assign pipe_rsp_q[0]   = in_rsp_i;
  assign pipe_valid_q[0] = in_valid_i;
  assign in_ready_o      = pipe_ready[0];

  // ------------------------------------------------------------
  // Register stages
  // ------------------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic reg_ena;

    // Advance when downstream takes data or holds only a bubble
    assign pipe_ready[i] = pipe_ready[i+1] | ~pipe_valid_q[i+1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        pipe_valid_q[i+1] <= 1'b0;
      end else if (pipe_ready[i]) begin
        pipe_valid_q[i+1] <= pipe_valid_q[i];
      end
    end

    // Load payload only for a real transfer
    assign reg_ena = pipe_ready[i] & pipe_valid_q[i];

    always_ff @(posedge clk_i) begin
      if (reg_ena) begin
        pipe_rsp_q[i+1] <= pipe_rsp_q[i];
      end
    end
  end

  // Last stage faces the consumer
  assign pipe_ready[NumPipeRegs] = out_ready_i;
  assign out_valid_o             = pipe_valid_q[NumPipeRegs];
  assign out_rsp_o               = pipe_rsp_q[NumPipeRegs];

endmodule

// File: fp_noncomp_top.sv
// Non-computational single-precision FPU
// Sign injection, min/max, comparison and classification with
// a valid/ready handshake and NumPipeRegs output register stages
`timescale 1ns/1ps

module fp_noncomp_top #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               in_valid_i,
  input  fp_op_pkg::fp_req_t req_i,
  output logic               in_ready_o,
  output logic               out_valid_o,
  output fp_op_pkg::fp_rsp_t rsp_o,
  input  logic               out_ready_i
);

  import fp_format_pkg::*;
  import fp_op_pkg::*;

  fp_info_t   info_a;
  fp_info_t   info_b;
  order_t     order;
  part_rsp_t  sgnj_rsp;
  part_rsp_t  minmax_rsp;
  part_rsp_t  cmp_rsp;
  classmask_e class_mask;
  fp_rsp_t    rsp_d;

  // ------------------------------------------------------------
  // Operand analysis
  // ------------------------------------------------------------
  fp_operand_analyzer fp_operand_analyzer_i (
    .a_i      ( req_i.a ),
    .b_i      ( req_i.b ),
    .info_a_o ( info_a  ),
    .info_b_o ( info_b  ),
    .order_o  ( order   )
  );

  // ------------------------------------------------------------
  // Result parts
  // ------------------------------------------------------------
  fp_sign_minmax fp_sign_minmax_i (
    .a_i      ( req_i.a      ),
    .b_i      ( req_i.b      ),
    .info_a_i ( info_a       ),
    .info_b_i ( info_b       ),
    .order_i  ( order        ),
    .sub_op_i ( req_i.sub_op ),
    .op_mod_i ( req_i.op_mod ),
    .sgnj_o   ( sgnj_rsp     ),
    .minmax_o ( minmax_rsp   )
  );

  fp_compare_class fp_compare_class_i (
    .a_i          ( req_i.a      ),
    .info_a_i     ( info_a       ),
    .order_i      ( order        ),
    .sub_op_i     ( req_i.sub_op ),
    .op_mod_i     ( req_i.op_mod ),
    .cmp_o        ( cmp_rsp      ),
    .class_mask_o ( class_mask   )
  );

  // Operation decode happens only here
  fp_result_select fp_result_select_i (
    .op_i         ( req_i.op   ),
    .tag_i        ( req_i.tag  ),
    .sgnj_i       ( sgnj_rsp   ),
    .minmax_i     ( minmax_rsp ),
    .cmp_i        ( cmp_rsp    ),
    .class_mask_i ( class_mask ),
    .rsp_o        ( rsp_d      )
  );

  // ------------------------------------------------------------
  // Output pipeline
  // ------------------------------------------------------------
  fp_pipe_stages #(
    .NumPipeRegs ( NumPipeRegs )
  ) fp_pipe_stages_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_rsp_i    ( rsp_d       ),
    .in_ready_o  ( in_ready_o  ),
    .out_valid_o ( out_valid_o ),
    .out_rsp_o   ( rsp_o       ),
    .out_ready_i ( out_ready_i )
  );

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset generator
// Free-running clock, active-low reset held for a set number of cycles
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned PeriodNs    = 100,
  parameter int unsigned ResetCycles = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin : make_clock
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2);
      clk_o = ~clk_o;
    end
  end

  initial begin : make_reset
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    // Release just after the edge
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// File: tb_fp_noncomp.sv
// Testbench for the non-computational FPU
// Reads transactions from the vector file, drives them over the
// valid/ready handshake under random back-pressure and checks
// every response, its tag, its order and its latency
`timescale 1ns/1ps

module tb_fp_noncomp;

  import fp_format_pkg::*;
  import fp_op_pkg::*;

  localparam int unsigned NUM_PIPE_REGS = 2;
  localparam int unsigned FIELDS        = 9;
  localparam int unsigned MAX_VECTORS   = 128;

  // Expected response and the cycle its request was taken
  typedef struct packed {
    fp_rsp_t     rsp;
    logic [31:0] issue_cycle;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  fp_req_t     req;
  logic        in_ready;
  logic        out_valid;
  fp_rsp_t     rsp;
  logic        out_ready;

  logic [31:0] vec_mem [0:FIELDS*MAX_VECTORS-1];
  expect_t     exp_q [$];
  int unsigned num_vectors;
  int unsigned rcv_count;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;
  int unsigned value_errors;
  int unsigned proto_errors;
  integer      seed;

  tb_clock_gen #(
    .PeriodNs    ( 100 ),
    .ResetCycles ( 10  )
  ) tb_clock_gen_i (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  fp_noncomp_top #(
    .NumPipeRegs ( NUM_PIPE_REGS )
  ) fp_noncomp_top_i (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .in_valid_i  ( in_valid  ),
    .req_i       ( req       ),
    .in_ready_o  ( in_ready  ),
    .out_valid_o ( out_valid ),
    .rsp_o       ( rsp       ),
    .out_ready_i ( out_ready )
  );

  // ------------------------------------------------------------
  // Compare tasks, one per kind of result
  // ------------------------------------------------------------
  task automatic check_word(input string name, input fp_word_u got, input fp_word_u exp);
    if (got.word !== exp.word) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got.word, exp.word);
      value_errors = value_errors + 1;
    end
  endtask

  task automatic check_status(input string name, input status_t got, input status_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      value_errors = value_errors + 1;
    end
  endtask

  task automatic check_class_mask(input string name, input classmask_e got,
                                  input classmask_e exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      value_errors = value_errors + 1;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      value_errors = value_errors + 1;
    end
  endtask

  task automatic check_tag(input string name, input logic [TAG_BITS-1:0] got,
                           input logic [TAG_BITS-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
      value_errors = value_errors + 1;
    end
  endtask

  // ------------------------------------------------------------
  // Vector loading and end of run
  // ------------------------------------------------------------
  task automatic load_vectors();
    // Unused words keep an address-dependent marker above any opcode
    for (int unsigned i = 0; i < FIELDS * MAX_VECTORS; i++) begin
      vec_mem[i] = {16'hF0F0, i[15:0]};
    end
    $readmemh("fp_noncomp_vectors.txt", vec_mem);
    num_vectors = 0;
    while (num_vectors < MAX_VECTORS && vec_mem[num_vectors*FIELDS] <= 32'd3) begin
      num_vectors = num_vectors + 1;
    end
    if (num_vectors == 0) begin
      $display("No vectors could be read from the vector file");
      proto_errors = proto_errors + 1;
    end
    cycle_limit = 20 * num_vectors + 100;
  endtask

  task automatic finish_run();
    $display("Error counts: %0d value mismatches, %0d protocol errors",
             value_errors, proto_errors);
    if (value_errors + proto_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  // ------------------------------------------------------------
  // Request driver
  // ------------------------------------------------------------
  initial begin : drive_requests
    int unsigned         base;
    logic [TAG_BITS-1:0] tag_cnt;
    expect_t             item;
    in_valid     = 1'b0;
    req          = '0;
    out_ready    = 1'b0;
    seed         = 32'hda09c5db;
    cycle_cnt    = 0;
    rcv_count    = 0;
    value_errors = 0;
    proto_errors = 0;
    tag_cnt      = '0;
    load_vectors();
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;
    for (int unsigned idx = 0; idx < num_vectors; idx++) begin
      base       = idx * FIELDS;
      in_valid   = 1'b1;
      req.op     = op_e'(vec_mem[base][1:0]);
      req.sub_op = vec_mem[base+1][1:0];
      req.op_mod = vec_mem[base+2][0];
      req.a      = vec_mem[base+3];
      req.b      = vec_mem[base+4];
      req.tag    = tag_cnt;
      // Expected response straight from the file columns
      item.rsp.result.word = vec_mem[base+5];
      item.rsp.status      = vec_mem[base+6][4:0];
      item.rsp.ext_bit     = vec_mem[base+7][0];
      item.rsp.class_mask  = classmask_e'(vec_mem[base+8][9:0]);
      item.rsp.is_class    = (req.op == CLASSIFY);
      item.rsp.tag         = tag_cnt;
      // Hold the request until the DUT is ready mid-cycle
      @(negedge clk);
      while (in_ready !== 1'b1) begin
        @(negedge clk);
      end
      item.issue_cycle = cycle_cnt;
      exp_q.push_back(item);
      tag_cnt = tag_cnt + 1'b1;
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
    req      = '0;
    wait (rcv_count == num_vectors);
    // Idle cycles to catch a duplicated response
    repeat (4) @(posedge clk);
    finish_run();
  end

  // Random back-pressure on the output
  always @(posedge clk) begin : drive_out_ready
    logic [31:0] rand_word;
    #1;
    rand_word = $random(seed);
    // Ready about three cycles in four
    out_ready = (rand_word[1:0] != 2'b00);
  end

  // ------------------------------------------------------------
  // Response monitor, sampled mid-cycle
  // ------------------------------------------------------------
  always @(negedge clk) begin : check_responses
    expect_t item;
    if (rst_n !== 1'b1) begin
      if (out_valid !== 1'b0) begin
        $display("Output valid is not low during reset at %0t", $time);
        proto_errors = proto_errors + 1;
      end
    end else if (out_valid === 1'b1 && out_ready === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Response at %0t with no request outstanding", $time);
        proto_errors = proto_errors + 1;
      end else begin
        item = exp_q.pop_front();
        check_word("rsp_o.result", rsp.result, item.rsp.result);
        check_status("rsp_o.status", rsp.status, item.rsp.status);
        check_bit("rsp_o.ext_bit", rsp.ext_bit, item.rsp.ext_bit);
        check_bit("rsp_o.is_class", rsp.is_class, item.rsp.is_class);
        check_tag("rsp_o.tag", rsp.tag, item.rsp.tag);
        // Mask only carries meaning for classification
        if (item.rsp.is_class) begin
          check_class_mask("rsp_o.class_mask", rsp.class_mask, item.rsp.class_mask);
        end
        if (cycle_cnt - item.issue_cycle < NUM_PIPE_REGS) begin
          $display("Response with tag %0d came %0d cycles after its request at %0t",
                   item.rsp.tag, cycle_cnt - item.issue_cycle, $time);
          proto_errors = proto_errors + 1;
        end
        rcv_count = rcv_count + 1;
      end
    end
  end

  // Cycle counter and run limit
  always @(posedge clk) begin : count_cycles
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles with %0d of %0d responses received",
               cycle_cnt, rcv_count, num_vectors);
      proto_errors = proto_errors + 1;
      finish_run();
    end
  end

endmodule

// File: fp_noncomp_vectors.txt
// op sub_op op_mod operand_a operand_b result status ext_bit class_mask, all hex
// status is {NV,DZ,OF,UF,NX}; class_mask is checked only for op 3 (classify)
// Sign injection
0 0 0 3F800000 C0000000 BF800000 00 1 000
0 1 0 3F800000 C0000000 3F800000 00 1 000
0 2 1 BF800000 C0000000 3F800000 00 0 000
0 3 1 C0400000 3F800000 C0400000 00 1 000
0 0 1 40000000 BF800000 C0000000 00 1 000
0 1 1 C0000000 BF800000 40000000 00 0 000
// Minimum and maximum
1 0 0 3F800000 40000000 3F800000 00 1 000
1 1 0 3F800000 40000000 40000000 00 1 000
1 0 0 BF800000 3F800000 BF800000 00 1 000
1 1 0 C0000000 BF800000 BF800000 00 1 000
1 0 0 00000000 80000000 80000000 00 1 000
1 1 0 80000000 00000000 00000000 00 1 000
1 0 0 7FC00000 40000000 40000000 00 1 000
1 1 0 3F800000 7F800001 3F800000 10 1 000
1 0 0 7FC00000 7F800001 7FC00000 10 1 000
1 1 0 7FC00000 FFC00000 7FC00000 00 1 000
// Comparison
2 0 0 3F800000 40000000 00000001 00 0 000
2 0 0 40000000 3F800000 00000000 00 0 000
2 0 1 40000000 3F800000 00000001 00 0 000
2 1 0 3F800000 3F800000 00000000 00 0 000
2 1 0 C0000000 BF800000 00000001 00 0 000
2 1 1 BF800000 C0000000 00000001 00 0 000
2 2 0 00000000 80000000 00000001 00 0 000
2 2 1 3F800000 40000000 00000001 00 0 000
2 0 0 80000000 00000000 00000001 00 0 000
2 1 0 80000000 00000000 00000000 00 0 000
2 0 0 7FC00000 3F800000 00000000 10 0 000
2 1 1 3F800000 7FC00000 00000000 10 0 000
2 2 0 7FC00000 3F800000 00000000 00 0 000
2 2 1 7FC00000 3F800000 00000001 00 0 000
2 2 0 7F800001 3F800000 00000000 10 0 000
2 2 1 3F800000 7F800001 00000000 10 0 000
// Classification
3 0 0 FF800000 00000000 00000000 00 0 001
3 0 0 BF800000 00000000 00000000 00 0 002
3 0 0 80000001 00000000 00000000 00 0 004
3 0 0 80000000 00000000 00000000 00 0 008
3 0 0 00000000 00000000 00000000 00 0 010
3 0 0 00000001 00000000 00000000 00 0 020
3 0 0 3F800000 00000000 00000000 00 0 040
3 0 0 7F800000 00000000 00000000 00 0 080
3 0 0 7F800001 00000000 00000000 00 0 100
3 0 0 7FC00000 00000000 00000000 00 0 200

// File: src.f
fp_format_pkg.sv
fp_op_pkg.sv
fp_operand_analyzer.sv
fp_sign_minmax.sv
fp_compare_class.sv
fp_result_select.sv
fp_pipe_stages.sv
fp_noncomp_top.sv
tb_clock_gen.sv
tb_fp_noncomp.sv

// File: Bender.yml
package:
  name: fp_noncomp

sources:
  - fp_format_pkg.sv
  - fp_op_pkg.sv
  - fp_operand_analyzer.sv
  - fp_sign_minmax.sv
  - fp_compare_class.sv
  - fp_result_select.sv
  - fp_pipe_stages.sv
  - fp_noncomp_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_fp_noncomp.sv
